// File: hw/rhythm_settings.svh
`ifndef RHYTHM_SETTINGS_SVH
`define RHYTHM_SETTINGS_SVH

// Lane length in notes
`define RHYTHM_MAP_BITS 191

// Judged tap positions at the front of the lane
`define TAP_MISS       0
`define TAP_GOOD_LATE  1
`define TAP_PERFECT    2
`define TAP_GOOD_EARLY 3

`define LED_COUNT 10
`define LED_BASE  2   // Lowest tap shown on the LEDs

`define BEAT_DIVISOR_DEFAULT 6250000  // 8 beats per second at 50 MHz
`define SCORE_BITS 8

`endif

// File: hw/game_pkg.sv
`include "rhythm_settings.svh"

package game_pkg;

  // Last result shown on the judgement display
  typedef enum logic [1:0] {
    JUDGE_NONE    = 2'd0,
    JUDGE_PERFECT = 2'd1,
    JUDGE_GOOD    = 2'd2,
    JUDGE_MISS    = 2'd3
  } judgement_t;

  typedef enum logic {
    STATE_IDLE    = 1'b0,
    STATE_PLAYING = 1'b1
  } game_state_t;

  typedef struct packed {
    logic [`SCORE_BITS/2-1:0] hi;
    logic [`SCORE_BITS/2-1:0] lo;
  } nibble_pair_t;

  // Score and combo word, counted as a whole and shown as two hex digits
  typedef union packed {
    logic [`SCORE_BITS-1:0] count;
    nibble_pair_t           nib;
  } score_word_t;

endpackage

// File: hw/display_pkg.sv
package display_pkg;

  // Active low, bit 0 is segment a, bit 6 is segment g
  typedef logic [6:0] seg7_t;

  localparam seg7_t GLYPH_NONE    = 7'h7F;  // All dark
  localparam seg7_t GLYPH_PERFECT = 7'h0C;  // P
  localparam seg7_t GLYPH_GOOD    = 7'h42;  // G
  localparam seg7_t GLYPH_MISS    = 7'h0E;  // F-like shape for miss

  function automatic seg7_t hex_digit(input logic [3:0] value);
    case (value)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'hA: return 7'h08;
      4'hB: return 7'h03;  // Lower case b
      4'hC: return 7'h46;
      4'hD: return 7'h21;  // Lower case d
      4'hE: return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

endpackage

// File: hw/game_control.sv
`timescale 1ns/1ns

module game_control (
  input  logic clk,
  input  logic rst,
  input  logic start,
  output logic playing,
  output logic load
);
  import game_pkg::*;

  game_state_t state;
  game_state_t state_next;

  // Start toggles between idle and play
  always_comb begin
    state_next = state;
    case (state)
      STATE_IDLE:    if (start) state_next = STATE_PLAYING;
      STATE_PLAYING: if (start) state_next = STATE_IDLE;
      default:       state_next = STATE_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= STATE_IDLE;
    end else begin
      state <= state_next;
    end
  end

  assign playing = (state == STATE_PLAYING);

  // Map is taken in on the same cycle as the start pulse
  assign load = start && (state == STATE_IDLE);

endmodule

// File: hw/beat_tick.sv
`timescale 1ns/1ns
`include "rhythm_settings.svh"

module beat_tick #(
  parameter int beat_divisor = `BEAT_DIVISOR_DEFAULT
) (
  input  logic clk,
  input  logic rst,
  input  logic playing,
  output logic tick
);
  localparam int CNT_W = $clog2(beat_divisor);

  logic [CNT_W-1:0] count;
  logic             wrap;
  logic             tick_q;

  assign wrap = (count == CNT_W'(beat_divisor - 1));

  always_ff @(posedge clk) begin
    if (!rst) begin
      count  <= '0;
      tick_q <= 1'b0;
    end else if (!playing) begin
      count  <= '0;   // Restart the beat on every entry to play
      tick_q <= 1'b0;
    end else begin
      count  <= wrap ? '0 : count + 1'b1;
      tick_q <= wrap;
    end
  end

  // A pending tick is dropped in the cycle play stops
  assign tick = tick_q & playing;

endmodule

// File: hw/note_lane.sv
`timescale 1ns/1ns
`include "rhythm_settings.svh"

module note_lane #(
  parameter int map_bits = `RHYTHM_MAP_BITS
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  load,
  input  logic [map_bits-1:0]   rhythm_map,
  input  logic                  tick,
  input  logic [3:0]            clear_mask,
  output logic [3:0]            taps,
  output logic [`LED_COUNT-1:0] leds
);
  localparam int PAD_BITS = map_bits - 4;

  logic [map_bits-1:0] lane;
  logic [map_bits-1:0] lane_cleared;
  logic [map_bits-1:0] lane_next;

  // Judged notes leave the lane before the shift
  assign lane_cleared = lane & ~{{PAD_BITS{1'b0}}, clear_mask};

  always_comb begin
    if (load) begin
      lane_next = rhythm_map;
    end else if (tick) begin
      lane_next = lane_cleared >> 1;
    end else begin
      lane_next = lane_cleared;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      lane <= '0;
    end else begin
      lane <= lane_next;
    end
  end

  assign taps = lane[3:0];                       // Tap 0 is the miss position
  assign leds = lane[`LED_BASE +: `LED_COUNT];   // Taps 11 down to 2

endmodule

// File: hw/hit_judge.sv
`timescale 1ns/1ns
`include "rhythm_settings.svh"

module hit_judge (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  playing,
  input  logic                  load,
  input  logic                  button,
  input  logic [3:0]            taps,
  output logic [3:0]            clear_mask,
  output game_pkg::score_word_t score,
  output game_pkg::score_word_t combo,
  output game_pkg::judgement_t  judgement
);
  import game_pkg::*;

  logic       button_q;
  logic       press;
  logic [3:0] hit_mask;
  logic [1:0] points;
  judgement_t hit_result;

  // Button is active low, so a press is a falling edge
  assign press = playing && button_q && !button;

  // Earliest note in the window wins
  always_comb begin
    hit_mask   = '0;
    points     = 2'd0;
    hit_result = JUDGE_NONE;
    if (taps[`TAP_GOOD_LATE]) begin
      hit_mask[`TAP_GOOD_LATE] = 1'b1;
      points                   = 2'd1;
      hit_result               = JUDGE_GOOD;
    end else if (taps[`TAP_PERFECT]) begin
      hit_mask[`TAP_PERFECT] = 1'b1;
      points                 = 2'd2;
      hit_result             = JUDGE_PERFECT;
    end else if (taps[`TAP_GOOD_EARLY]) begin
      hit_mask[`TAP_GOOD_EARLY] = 1'b1;
      points                    = 2'd1;
      hit_result                = JUDGE_GOOD;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      button_q   <= 1'b1;   // Released
      clear_mask <= '0;
      score      <= '0;
      combo      <= '0;
      judgement  <= JUDGE_NONE;
    end else begin
      button_q   <= button;
      clear_mask <= '0;
      if (load) begin
        score     <= '0;
        combo     <= '0;
        judgement <= JUDGE_NONE;
      end else if (playing) begin
        if (press) begin
          clear_mask  <= hit_mask;
          score.count <= score.count + `SCORE_BITS'(points);
          judgement   <= hit_result;   // Empty window shows a dark judgement
          if (|hit_mask) begin
            combo.count <= combo.count + 1'b1;
          end
        end
        // A note at tap 0 overrides the hit's judgement and combo
        if (taps[`TAP_MISS]) begin
          combo.count <= '0;
          judgement   <= JUDGE_MISS;
        end
      end
    end
  end

endmodule

// File: hw/score_display.sv
`timescale 1ns/1ns

module score_display (
  input  game_pkg::score_word_t score,
  input  game_pkg::score_word_t combo,
  input  game_pkg::judgement_t  judgement,
  output display_pkg::seg7_t    hex_score_lo,
  output display_pkg::seg7_t    hex_score_hi,
  output display_pkg::seg7_t    hex_combo_lo,
  output display_pkg::seg7_t    hex_combo_hi,
  output display_pkg::seg7_t    hex_judge
);
  import game_pkg::*;
  import display_pkg::*;

  // Each word is shown as two hex digits
  assign hex_score_lo = hex_digit(score.nib.lo);
  assign hex_score_hi = hex_digit(score.nib.hi);
  assign hex_combo_lo = hex_digit(combo.nib.lo);
  assign hex_combo_hi = hex_digit(combo.nib.hi);

  always_comb begin
    case (judgement)
      JUDGE_PERFECT: hex_judge = GLYPH_PERFECT;
      JUDGE_GOOD:    hex_judge = GLYPH_GOOD;
      JUDGE_MISS:    hex_judge = GLYPH_MISS;
      default:       hex_judge = GLYPH_NONE;   // No result yet or empty press
    endcase
  end

endmodule

// File: hw/rhythm_top.sv
`timescale 1ns/1ns
`include "rhythm_settings.svh"

module rhythm_top #(
  parameter int beat_divisor = `BEAT_DIVISOR_DEFAULT,
  parameter int map_bits     = `RHYTHM_MAP_BITS
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  logic                  button,
  input  logic [map_bits-1:0]   rhythm_map,
  output logic [`LED_COUNT-1:0] leds,
  output logic                  playing,
  output display_pkg::seg7_t    hex_score_lo,
  output display_pkg::seg7_t    hex_score_hi,
  output display_pkg::seg7_t    hex_combo_lo,
  output display_pkg::seg7_t    hex_combo_hi,
  output display_pkg::seg7_t    hex_judge
);
  import game_pkg::*;

  logic        load;
  logic        tick;
  logic [3:0]  taps;
  logic [3:0]  clear_mask;
  score_word_t score;
  score_word_t combo;
  judgement_t  judgement;

  game_control u_game_control (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .playing (playing),
    .load    (load)
  );

  beat_tick #(
    .beat_divisor (beat_divisor)
  ) u_beat_tick (
    .clk     (clk),
    .rst     (rst),
    .playing (playing),
    .tick    (tick)
  );

  note_lane #(
    .map_bits (map_bits)
  ) u_note_lane (
    .clk        (clk),
    .rst        (rst),
    .load       (load),
    .rhythm_map (rhythm_map),
    .tick       (tick),
    .clear_mask (clear_mask),
    .taps       (taps),
    .leds       (leds)
  );

  hit_judge u_hit_judge (
    .clk        (clk),
    .rst        (rst),
    .playing    (playing),
    .load       (load),
    .button     (button),
    .taps       (taps),
    .clear_mask (clear_mask),
    .score      (score),
    .combo      (combo),
    .judgement  (judgement)
  );

  score_display u_score_display (
    .score        (score),
    .combo        (combo),
    .judgement    (judgement),
    .hex_score_lo (hex_score_lo),
    .hex_score_hi (hex_score_hi),
    .hex_combo_lo (hex_combo_lo),
    .hex_combo_hi (hex_combo_hi),
    .hex_judge    (hex_judge)
  );

endmodule

// File: verification/rhythm_assertions.sv
`timescale 1ns/1ns

module rhythm_assertions (
  input logic                  clk,
  input logic                  rst,
  input logic                  playing,
  input logic                  tick,
  input logic [3:0]            taps,
  input logic [3:0]            clear_mask,
  input game_pkg::score_word_t score,
  input game_pkg::judgement_t  judgement
);
  import game_pkg::*;

  int failures = 0;

  // Beats only run during play, counted from a cycle that was already playing
  a_tick_only_playing: assert property (@(posedge clk) disable iff (!rst)
    tick |-> playing && $past(playing))
    else begin
      $error("tick high while idle");
      failures++;
    end

  a_clear_only_notes: assert property (@(posedge clk) disable iff (!rst)
    (clear_mask & ~taps) == 4'b0000)
    else begin
      $error("clear mask removes an empty tap");
      failures++;
    end

  // At most a perfect per cycle, or a load clears it
  a_score_step: assert property (@(posedge clk) disable iff (!rst)
    (8'(score.count - $past(score.count)) <= 8'd2) || (score.count == 8'd0))
    else begin
      $error("score rose by more than 2");
      failures++;
    end

  a_judge_after_reset: assert property (@(posedge clk)
    $rose(rst) |-> judgement == JUDGE_NONE)
    else begin
      $error("judgement not none after reset");
      failures++;
    end

endmodule

// File: verification/tb_rhythm_top.sv
`timescale 1ns/1ns
`include "rhythm_settings.svh"

module tb_rhythm_top;
  localparam int MAP_BITS  = `RHYTHM_MAP_BITS;
  localparam int MAX_TESTS = 16;
  localparam int DIVISOR   = 8;

  logic                  clk;
  logic                  rst;
  logic                  start;
  logic                  button;
  logic [MAP_BITS-1:0]   rhythm_map;
  logic [`LED_COUNT-1:0] leds;
  logic                  playing;
  logic [6:0]            hex_score_lo;
  logic [6:0]            hex_score_hi;
  logic [6:0]            hex_combo_lo;
  logic [6:0]            hex_combo_hi;
  logic [6:0]            hex_judge;

  int                  seed;
  int                  errors;
  int                  tests_passed;
  int                  tests_failed;
  int                  num_tests;
  int                  limit_cycles;
  int                  code_arr  [MAX_TESTS];
  logic [MAP_BITS-1:0] map_arr   [MAX_TESTS];
  int                  beats_arr [MAX_TESTS];
  logic [63:0]         press_arr [MAX_TESTS];
  logic [7:0]          score_arr [MAX_TESTS];
  logic [7:0]          combo_arr [MAX_TESTS];
  int                  judge_arr [MAX_TESTS];
  logic [9:0]          leds_arr  [MAX_TESTS];

  rhythm_top #(
    .beat_divisor (DIVISOR)
  ) u_dut (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .button       (button),
    .rhythm_map   (rhythm_map),
    .leds         (leds),
    .playing      (playing),
    .hex_score_lo (hex_score_lo),
    .hex_score_hi (hex_score_hi),
    .hex_combo_lo (hex_combo_lo),
    .hex_combo_hi (hex_combo_hi),
    .hex_judge    (hex_judge)
  );

  always #10 clk = ~clk;  // 20 ns period

  // Reference segment shapes, active low, bit 0 is segment a
  function automatic logic [6:0] digit_segments(input logic [3:0] value);
    logic [6:0] table_segs [16];
    table_segs = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                   7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
    return table_segs[value];
  endfunction

  function automatic logic [6:0] judge_segments(input int judge);
    case (judge)
      1:       return 7'h0C;  // P, segments a b e f g
      2:       return 7'h42;  // G, segments a c d e f
      3:       return 7'h0E;  // Miss, segments a e f g
      default: return 7'h7F;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s expected %h got %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_outputs(input logic [9:0] exp_leds, input logic [7:0] exp_score,
                               input logic [7:0] exp_combo, input int exp_judge);
    check_value("leds", 32'(exp_leds), 32'(leds));
    check_value("hex_score_lo", 32'(digit_segments(exp_score[3:0])), 32'(hex_score_lo));
    check_value("hex_score_hi", 32'(digit_segments(exp_score[7:4])), 32'(hex_score_hi));
    check_value("hex_combo_lo", 32'(digit_segments(exp_combo[3:0])), 32'(hex_combo_lo));
    check_value("hex_combo_hi", 32'(digit_segments(exp_combo[7:4])), 32'(hex_combo_hi));
    check_value("hex_judge", 32'(judge_segments(exp_judge)), 32'(hex_judge));
  endtask

  task automatic load_tests();
    int    fd;
    int    got;
    string line;
    fd = $fopen("verification/rhythm_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test data file");
      errors++;
      return;
    end
    while (!$feof(fd) && num_tests < MAX_TESTS) begin
      line = "";
      got  = $fgets(line, fd);
      if (line.len() < 4 || line.getc(0) == 8'h23) continue;  // Blank or comment
      got = $sscanf(line, "%d %h %d %h %h %h %d %h", code_arr[num_tests],
                    map_arr[num_tests], beats_arr[num_tests], press_arr[num_tests],
                    score_arr[num_tests], combo_arr[num_tests], judge_arr[num_tests],
                    leds_arr[num_tests]);
      if (got == 8) num_tests++;
    end
    $fclose(fd);
  endtask

  // Random button levels while idle, then released
  task automatic idle_chatter();
    int rnd;
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      rnd = $random(seed);
      button <= rnd[0];
    end
    @(posedge clk);
    button <= 1'b1;
  endtask

  task automatic run_test(input int idx);
    int errors_before;
    int beat;
    errors_before = errors;
    idle_chatter();
    @(posedge clk);
    rhythm_map <= map_arr[idx];
    start      <= 1'b1;
    @(negedge clk);
    check_value("playing", 32'd0, 32'(playing));
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    check_value("playing", 32'd1, 32'(playing));  // One cycle after start
    check_outputs(map_arr[idx][11:2], 8'h00, 8'h00, 0);
    for (int i = 0; i < beats_arr[idx] * DIVISOR; i++) begin
      @(posedge clk);
      beat = i / DIVISOR;
      if (press_arr[idx][beat % 64]) begin
        if (i % DIVISOR == 3) button <= 1'b0;
        if (i % DIVISOR == 6) button <= 1'b1;
      end
    end
    @(posedge clk);
    start <= 1'b1;   // Stop play
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    check_value("playing", 32'd0, 32'(playing));
    check_outputs(leds_arr[idx], score_arr[idx], combo_arr[idx], judge_arr[idx]);
    idle_chatter();
    @(negedge clk);
    check_outputs(leds_arr[idx], score_arr[idx], combo_arr[idx], judge_arr[idx]);
    if (errors == errors_before) begin
      tests_passed++;
      $display("Test %0d code %0d ok", idx, code_arr[idx]);
    end else begin
      tests_failed++;
      $display("Test %0d code %0d FAILED", idx, code_arr[idx]);
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b0;
    start        = 1'b0;
    button       = 1'b1;
    rhythm_map   = '0;
    seed         = 88;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    num_tests    = 0;
    limit_cycles = 0;
    load_tests();
    limit_cycles = 200;
    for (int i = 0; i < num_tests; i++) begin
      limit_cycles += beats_arr[i] * DIVISOR + 80;
    end
    repeat (8) @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    check_value("playing", 32'd0, 32'(playing));
    check_outputs(10'h000, 8'h00, 8'h00, 0);
    @(posedge clk);
    button <= 1'b0;  // Press while idle does nothing
    repeat (3) @(posedge clk);
    button <= 1'b1;
    repeat (2) @(negedge clk);
    check_outputs(10'h000, 8'h00, 8'h00, 0);
    if (errors == 0) begin
      tests_passed++;
      $display("Reset and idle ok");
    end else begin
      tests_failed++;
      $display("Reset and idle FAILED");
    end
    if (num_tests == 0) begin
      $display("No tests found in the data file");
      errors++;
    end
    for (int i = 0; i < num_tests; i++) begin
      run_test(i);
    end
    errors += u_dut.u_assertions.failures;
    $display("Tests %0d, passed %0d, failed %0d, errors %0d",
             tests_passed + tests_failed, tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog sized from the beats in the data file
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Run did not finish within %0d cycles, the testbench hung", limit_cycles);
    $display("sim failed");
    $finish;
  end

endmodule

bind rhythm_top rhythm_assertions u_assertions (
  .clk        (clk),
  .rst        (rst),
  .playing    (playing),
  .tick       (tick),
  .taps       (taps),
  .clear_mask (clear_mask),
  .score      (score),
  .judgement  (judgement)
);

// File: vlog.f
+incdir+hw
hw/game_pkg.sv
hw/display_pkg.sv
hw/game_control.sv
hw/beat_tick.sv
hw/note_lane.sv
hw/hit_judge.sv
hw/score_display.sv
hw/rhythm_top.sv
verification/rhythm_assertions.sv
verification/tb_rhythm_top.sv

// File: Makefile
# Verilator build and run for the rhythm game core

VERILATOR ?= verilator
TOP       ?= tb_rhythm_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing
PASS_TEXT ?= sim passed

SOURCES := $(wildcard hw/*.sv hw/*.svh verification/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) verification/rhythm_testdata.txt
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/rhythm_testdata.txt
# code map_hex beats press_mask score combo judgement leds (all hex except code and beats)
# judgement 0 none, 1 perfect, 2 good, 3 miss; press mask bit n presses in beat n mod 64
1 3ff000 4 0 00 00 0 3c0
2 4110 14 884 04 03 2 000
3 100060 10 208 02 00 0 100
4 100284 11 21 04 00 3 080
5 7ffffffffffffffffffffffffffffffffffffffffffffffc 130 ffffffffffffffff 04 82 1 3ff
